// ==== hdl/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// reorder buffer
`define ROB_DEPTH 8
`define TAG_W 3

// datapath widths
`define DATA_W 32
`define OPND_W 12
`define IMM_W 24
`define RD_W 4

// multiplier pipeline depth, also the reservation depth on the result bus
`define MUL_LAT 3

`endif

// ==== hdl/isa_pkg.sv ====
`include "core_macros.svh"

package isa_pkg;

	// opcodes outside this set decode as mov
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		MUL = 4'd2,
		MOV = 4'd3
	} op_t;

	// add, sub, mul
	typedef struct packed {
		op_t op;
		logic [`RD_W-1:0] rd;
		logic signed [`OPND_W-1:0] a;
		logic signed [`OPND_W-1:0] b;
	} rform_t;

	// mov and anything unknown
	typedef struct packed {
		op_t op;
		logic [`RD_W-1:0] rd;
		logic signed [`IMM_W-1:0] imm;
	} iform_t;

	typedef union packed {
		rform_t r;
		iform_t i;
	} instr_t;

endpackage

// ==== hdl/bus_pkg.sv ====
`include "core_macros.svh"

package bus_pkg;

	// reorder buffer index
	typedef logic [`TAG_W-1:0] tag_t;

	typedef logic [`DATA_W-1:0] data_t;

	// one result per cycle
	typedef struct packed {
		logic valid;
		tag_t tag;
		data_t data;
	} cdb_t;

	// data source of a bus slot
	typedef enum logic {
		UNIT_ALU = 1'b0,
		UNIT_MUL = 1'b1
	} unit_sel_t;

endpackage

// ==== hdl/unit_req_if.sv ====
interface unit_req_if;
	import isa_pkg::*;
	import bus_pkg::*;

	logic valid;
	tag_t tag;
	op_t op;
	data_t a;
	data_t b;

	modport issue (output valid, tag, op, a, b);

	modport unit (input valid, tag, op, a, b);

	// scheduler only watches
	modport monitor (input valid, tag, op, a, b);
endinterface

// ==== hdl/alu_unit.sv ====
module alu_unit (
	input logic clk,
	input logic rst_n,
	unit_req_if.unit req,
	output bus_pkg::data_t result
);
	import isa_pkg::*;
	import bus_pkg::*;

	data_t value;

	always_comb begin
		case (req.op)
			ADD: begin
				value = req.a + req.b;
			end
			SUB: begin
				value = req.a - req.b;
			end
			// mov and undefined opcodes pass operand a
			default: begin
				value = req.a;
			end
		endcase
	end

	// on the bus the cycle after acceptance
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else if (req.valid) begin
			result <= value;
		end
	end
endmodule

// ==== hdl/mul_unit.sv ====
`include "core_macros.svh"

module mul_unit (
	input logic clk,
	input logic rst_n,
	unit_req_if.unit req,
	output bus_pkg::data_t result
);
	import bus_pkg::*;

	// stage_vld[i] set while stage i holds live work
	logic [`MUL_LAT-2:0] stage_vld;
	data_t opnd_a;
	data_t opnd_b;
	data_t prod [1:`MUL_LAT-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage_vld <= '0;
		end else begin
			stage_vld <= {stage_vld[`MUL_LAT-3:0], req.valid};
		end
	end

	// stage 0 latches operands
	always_ff @(posedge clk) begin
		if (req.valid) begin
			opnd_a <= req.a;
			opnd_b <= req.b;
		end
	end

	// stage 1 multiplies, low word only
	always_ff @(posedge clk) begin
		if (stage_vld[0]) begin
			prod[1] <= $signed(opnd_a) * $signed(opnd_b);
		end
		for (int i = 2; i < `MUL_LAT; i++) begin
			if (stage_vld[i-1]) begin
				prod[i] <= prod[i-1];
			end
		end
	end

	assign result = prod[`MUL_LAT-1];
endmodule

// ==== hdl/cdb_sched.sv ====
`include "core_macros.svh"

module cdb_sched (
	input logic clk,
	input logic rst_n,
	unit_req_if.monitor alu_req,
	unit_req_if.monitor mul_req,
	input bus_pkg::data_t alu_result,
	input bus_pkg::data_t mul_result,
	output logic alu_ready,
	output bus_pkg::cdb_t cdb
);
	import bus_pkg::*;

	////////////////////////////////////////////////////////////
	// reservations, slot 0 is on the bus this cycle
	////////////////////////////////////////////////////////////
	logic [`MUL_LAT-1:0] rsv_valid;
	tag_t rsv_tag [`MUL_LAT];
	unit_sel_t rsv_unit [`MUL_LAT];

	// slot 1 moves into slot 0 next edge, so an alu result would collide
	assign alu_ready = !rsv_valid[1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsv_valid <= '0;
		end else begin
			rsv_valid[`MUL_LAT-1] <= mul_req.valid;
			for (int i = 1; i < `MUL_LAT - 1; i++) begin
				rsv_valid[i] <= rsv_valid[i+1];
			end
			rsv_valid[0] <= rsv_valid[1] || alu_req.valid;
		end
	end

	always_ff @(posedge clk) begin
		rsv_tag[`MUL_LAT-1] <= mul_req.tag;
		rsv_unit[`MUL_LAT-1] <= UNIT_MUL;
		for (int i = 1; i < `MUL_LAT - 1; i++) begin
			rsv_tag[i] <= rsv_tag[i+1];
			rsv_unit[i] <= rsv_unit[i+1];
		end
		// longer latency keeps its slot
		if (rsv_valid[1]) begin
			rsv_tag[0] <= rsv_tag[1];
			rsv_unit[0] <= rsv_unit[1];
		end else begin
			rsv_tag[0] <= alu_req.tag;
			rsv_unit[0] <= UNIT_ALU;
		end
	end

	////////////////////////////////////////////////////////////
	// result bus
	////////////////////////////////////////////////////////////
	always_comb begin
		cdb.valid = rsv_valid[0];
		cdb.tag = rsv_tag[0];
		if (rsv_unit[0] == UNIT_MUL) begin
			cdb.data = mul_result;
		end else begin
			cdb.data = alu_result;
		end
	end
endmodule

// ==== hdl/rob_ptrs.sv ====
`include "core_macros.svh"

module rob_ptrs (
	input logic clk,
	input logic rst_n,
	input logic alloc,
	input logic retire,
	output bus_pkg::tag_t head,
	output bus_pkg::tag_t tail,
	output logic full
);
	import bus_pkg::*;

	logic [`TAG_W:0] count;

	function automatic tag_t wrap_inc(tag_t ptr);
		return (ptr == tag_t'(`ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (alloc) begin
				tail <= wrap_inc(tail);
			end
			if (retire) begin
				head <= wrap_inc(head);
			end
			// both at once leaves the count alone
			case ({alloc, retire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign full = count == (`TAG_W+1)'(`ROB_DEPTH);
endmodule

// ==== hdl/rob.sv ====
`include "core_macros.svh"

module rob (
	input logic clk,
	input logic rst_n,
	input logic alloc,
	input logic [`RD_W-1:0] alloc_rd,
	output bus_pkg::tag_t alloc_tag,
	output logic full,
	input bus_pkg::cdb_t cdb,
	output logic commit_valid,
	input logic commit_ready,
	output logic [`RD_W-1:0] commit_rd,
	output bus_pkg::data_t commit_data,
	output bus_pkg::tag_t commit_tag
);
	import bus_pkg::*;

	logic [`ROB_DEPTH-1:0] done;
	logic [`RD_W-1:0] rd_mem [`ROB_DEPTH];
	data_t data_mem [`ROB_DEPTH];
	tag_t head;
	tag_t tail;
	logic retire;

	////////////////////////////////////////////////////////////
	// pointers
	////////////////////////////////////////////////////////////
	rob_ptrs rob_ptrs (
		.clk,
		.rst_n,
		.alloc,
		.retire,
		.head,
		.tail,
		.full
	);

	assign alloc_tag = tail;
	assign retire = commit_valid && commit_ready;

	////////////////////////////////////////////////////////////
	// entries
	////////////////////////////////////////////////////////////

	// cleared on retire too, else an empty buffer shows a stale head
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done <= '0;
		end else begin
			if (alloc) begin
				done[tail] <= 1'b0;
			end
			if (retire) begin
				done[head] <= 1'b0;
			end
			if (cdb.valid) begin
				done[cdb.tag] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc) begin
			rd_mem[tail] <= alloc_rd;
		end
		if (cdb.valid) begin
			data_mem[cdb.tag] <= cdb.data;
		end
	end

	// head entry straight out, held until taken
	assign commit_valid = done[head];
	assign commit_rd = rd_mem[head];
	assign commit_data = data_mem[head];
	assign commit_tag = head;
endmodule

// ==== hdl/exec_core.sv ====
`include "core_macros.svh"

module exec_core (
	input logic clk,
	input logic rst_n,
	input isa_pkg::instr_t instr,
	input logic instr_valid,
	output logic instr_ready,
	output logic commit_valid,
	input logic commit_ready,
	output logic [`RD_W-1:0] commit_rd,
	output bus_pkg::data_t commit_data,
	output bus_pkg::tag_t commit_tag
);
	import isa_pkg::*;
	import bus_pkg::*;

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////
	op_t op;
	logic is_mul;
	logic reg_form;
	data_t opnd_a;
	data_t opnd_b;

	assign op = instr.r.op;
	assign is_mul = op == MUL;
	assign reg_form = op == ADD || op == SUB || op == MUL;

	// immediate form only for mov and unknown opcodes
	assign opnd_a = reg_form ? data_t'($signed(instr.r.a)) : data_t'($signed(instr.i.imm));
	assign opnd_b = data_t'($signed(instr.r.b));

	////////////////////////////////////////////////////////////
	// issue
	////////////////////////////////////////////////////////////
	logic full;
	logic alu_ready;
	logic accept;
	tag_t next_tag;
	data_t alu_result;
	data_t mul_result;
	cdb_t cdb;

	unit_req_if alu_req();
	unit_req_if mul_req();

	// mul never waits for the bus, its slot is always free
	assign instr_ready = !full && (is_mul || alu_ready);
	assign accept = instr_valid && instr_ready;

	assign alu_req.valid = accept && !is_mul;
	assign alu_req.tag = next_tag;
	assign alu_req.op = op;
	assign alu_req.a = opnd_a;
	assign alu_req.b = opnd_b;

	assign mul_req.valid = accept && is_mul;
	assign mul_req.tag = next_tag;
	assign mul_req.op = op;
	assign mul_req.a = opnd_a;
	assign mul_req.b = opnd_b;

	////////////////////////////////////////////////////////////
	// units, bus, commit
	////////////////////////////////////////////////////////////
	alu_unit alu_unit (.clk, .rst_n, .req(alu_req), .result(alu_result));

	mul_unit mul_unit (.clk, .rst_n, .req(mul_req), .result(mul_result));

	cdb_sched cdb_sched (
		.clk,
		.rst_n,
		.alu_req,
		.mul_req,
		.alu_result,
		.mul_result,
		.alu_ready,
		.cdb
	);

	rob rob (
		.clk,
		.rst_n,
		.alloc(accept),
		.alloc_rd(instr.r.rd),
		.alloc_tag(next_tag),
		.full,
		.cdb,
		.commit_valid,
		.commit_ready,
		.commit_rd,
		.commit_data,
		.commit_tag
	);
endmodule

// ==== tests/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clk
);
	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk;
endmodule

// ==== tests/exec_core_asserts.sv ====
module exec_core_asserts (
	input logic clk,
	input logic rst_n,
	input logic alu_accept,
	input logic slot_above,
	input logic commit_valid,
	input logic commit_ready,
	input bus_pkg::data_t commit_data,
	input logic alloc,
	input logic full
);
	int fail_count = 0;

	// alu result would land in a slot a mul already holds
	alu_slot_free: assert property (@(posedge clk) disable iff (!rst_n)
		alu_accept |-> !slot_above)
		else begin
			fail_count++;
			$error("alu operation accepted while the slot above the bus is reserved");
		end

	commit_held: assert property (@(posedge clk) disable iff (!rst_n)
		commit_valid && !commit_ready |=> commit_valid && $stable(commit_data))
		else begin
			fail_count++;
			$error("commit output changed while commit_ready was low");
		end

	no_alloc_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		full |-> !alloc)
		else begin
			fail_count++;
			$error("reorder buffer allocated while full");
		end
endmodule

bind cdb_sched exec_core_asserts sched_asserts (.clk, .rst_n,
	.alu_accept(alu_req.valid), .slot_above(rsv_valid[1]),
	.commit_valid(1'b0), .commit_ready(1'b1), .commit_data('0), .alloc(1'b0), .full(1'b0));

bind rob exec_core_asserts rob_asserts (.clk, .rst_n, .alu_accept(1'b0), .slot_above(1'b0),
	.commit_valid, .commit_ready, .commit_data, .alloc, .full);

// ==== tests/exec_core_tb.sv ====
`include "core_macros.svh"

module exec_core_tb;
	import isa_pkg::*;
	import bus_pkg::*;

	localparam int N_INSTR = 250;
	localparam int CYC_PER_INSTR = 40;

	typedef struct packed {
		logic [`RD_W-1:0] rd;
		data_t data;
		tag_t tag;
	} expect_t;

	logic clk;
	logic rst_n = 1'b0;
	instr_t instr = '0;
	logic instr_valid = 1'b0;
	logic instr_ready;
	logic commit_valid;
	logic commit_ready = 1'b0;
	logic [`RD_W-1:0] commit_rd;
	data_t commit_data;
	tag_t commit_tag;

	logic [31:0] stim_seed = 32'h56dc;
	logic [31:0] ready_seed = 32'h56dc;
	// 0 ready high, 1 random, 2 held low
	int ready_mode = 0;
	int accepted = 0;
	int data_errs = 0;
	int tag_errs = 0;
	int rd_errs = 0;
	int assert_errs = 0;
	int other_errs = 0;
	expect_t exp_q[$];
	logic [`OPND_W-1:0] edge_v [3] = '{12'h800, 12'h7ff, 12'h000};
	logic [`IMM_W-1:0] imm_v [3] = '{24'h800000, 24'h7fffff, 24'h000000};

	tb_clock #(.PERIOD(4)) clock_gen (.clk);

	exec_core uut (.*);

	function automatic logic [31:0] lcg(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic data_t expected_result(instr_t w);
		data_t a;
		data_t b;
		data_t imm;
		a = {{(`DATA_W - `OPND_W){w.r.a[`OPND_W-1]}}, w.r.a};
		b = {{(`DATA_W - `OPND_W){w.r.b[`OPND_W-1]}}, w.r.b};
		imm = {{(`DATA_W - `IMM_W){w.i.imm[`IMM_W-1]}}, w.i.imm};
		case (w.r.op)
			ADD: return a + b;
			SUB: return a - b;
			MUL: return a * b;
			default: return imm;
		endcase
	endfunction

	function automatic instr_t make_instr(op_t op, logic [`RD_W-1:0] rd, logic [`IMM_W-1:0] f);
		instr_t w;
		w.i.imm = f;
		w.r.op = op;
		w.r.rd = rd;
		return w;
	endfunction

	function automatic instr_t random_instr();
		logic [31:0] r1;
		logic [31:0] r2;
		stim_seed = lcg(stim_seed);
		r1 = stim_seed;
		stim_seed = lcg(stim_seed);
		r2 = stim_seed;
		// now and then an undefined opcode
		if (r1[27:25] == 3'd0) begin
			return make_instr(op_t'({2'b01, r1[31:30]}), r1[23:20], r2[30:7]);
		end
		return make_instr(op_t'({2'b00, r1[29:28]}), r1[23:20], r2[30:7]);
	endfunction

	task automatic check_data(input data_t got, input data_t exp);
		if (got !== exp) begin
			data_errs++;
			$display("** Error: commit_data got %h expected %h", got, exp);
		end
	endtask

	task automatic check_tag(input tag_t got, input tag_t exp);
		if (got !== exp) begin
			tag_errs++;
			$display("** Error: commit_tag got %h expected %h", got, exp);
		end
	endtask

	task automatic check_rd(input logic [`RD_W-1:0] got, input logic [`RD_W-1:0] exp);
		if (got !== exp) begin
			rd_errs++;
			$display("** Error: commit_rd got %h expected %h", got, exp);
		end
	endtask

	// holds the offer until the accepting edge
	task automatic issue(input instr_t w, output int stalls);
		expect_t e;
		stalls = 0;
		instr = w;
		instr_valid = 1'b1;
		@(negedge clk);
		while (!instr_ready) begin
			stalls++;
			@(negedge clk);
		end
		e.rd = w.r.rd;
		e.data = expected_result(w);
		e.tag = tag_t'(accepted % `ROB_DEPTH);
		exp_q.push_back(e);
		accepted++;
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	always @(posedge clk) begin
		int mode;
		mode = ready_mode;
		#1;
		if (mode == 1) begin
			ready_seed = lcg(ready_seed);
			commit_ready = ready_seed[29:28] != 2'b00;
		end else begin
			commit_ready = mode == 0;
		end
	end

	////////////////////////////////////////////////////////////
	// compare on each commit transfer
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		expect_t head_exp;
		if (rst_n && commit_valid && commit_ready) begin
			if (exp_q.size() == 0) begin
				other_errs++;
				$display("commit of tag %h with no instruction outstanding", commit_tag);
			end else begin
				head_exp = exp_q.pop_front();
				check_data(commit_data, head_exp.data);
				check_tag(commit_tag, head_exp.tag);
				check_rd(commit_rd, head_exp.rd);
			end
		end
	end

	initial begin
		#((N_INSTR * CYC_PER_INSTR + 10) * 4);
		$display("watchdog expired, commits stopped with %0d outstanding", exp_q.size());
		$display("test failed");
		$finish;
	end

	initial begin
		instr_t w;
		int stalls;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		if (!instr_ready || commit_valid) begin
			other_errs++;
			$display("instr_ready low or commit_valid high right after reset");
		end
		@(posedge clk);
		#1;

		// add, sub, mul over edge operands, then mov
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < 3; i++) begin
				for (int j = 0; j < 3; j++) begin
					w = make_instr(op_t'(k), 4'(i * 3 + j), {edge_v[i], edge_v[j]});
					issue(w, stalls);
				end
			end
		end
		for (int i = 0; i < 3; i++) begin
			issue(make_instr(MOV, 4'(i + 9), imm_v[i]), stalls);
		end
		drain();

		ready_mode = 1;
		repeat (200) issue(random_instr(), stalls);
		drain();

		// alu offered two edges after a mul waits one edge
		ready_mode = 0;
		issue(make_instr(MUL, 4'd1, {12'hffd, 12'h123}), stalls);
		@(posedge clk);
		#1;
		issue(make_instr(SUB, 4'd2, {12'h010, 12'h7ff}), stalls);
		if (stalls != 1) begin
			other_errs++;
			$display("alu op behind a mul stalled %0d cycles instead of 1", stalls);
		end
		drain();

		// back-pressure fills the buffer
		ready_mode = 2;
		for (int n = 0; n < `ROB_DEPTH; n++) begin
			w = random_instr();
			issue(make_instr(ADD, 4'd5, w.i.imm), stalls);
		end
		w = make_instr(ADD, 4'd6, 24'h001001);
		instr = w;
		instr_valid = 1'b1;
		repeat (16) begin
			@(negedge clk);
			if (instr_ready) begin
				other_errs++;
				$display("instr_ready high with a full reorder buffer");
			end
		end
		ready_mode = 0;
		@(posedge clk);
		#1;
		issue(w, stalls);
		issue(random_instr(), stalls);
		drain();

		assert_errs = uut.cdb_sched.sched_asserts.fail_count
			+ uut.rob.rob_asserts.fail_count;
		$display("errors: data %0d, tag %0d, rd %0d, assertion %0d, other %0d",
			data_errs, tag_errs, rd_errs, assert_errs, other_errs);
		if (data_errs + tag_errs + rd_errs + assert_errs + other_errs == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end
endmodule

// ==== exec_core.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/bus_pkg.sv
hdl/unit_req_if.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/cdb_sched.sv
hdl/rob_ptrs.sv
hdl/rob.sv
hdl/exec_core.sv
tests/tb_clock.sv
tests/exec_core_asserts.sv
tests/exec_core_tb.sv
